/* verilog/runner_pkg.sv */
package runner_pkg;

  // ============================================================
  // game state machine
  // ============================================================
  typedef enum logic [2:0] {
    restart   = 3'd0,
    jumping   = 3'd1,
    running1  = 3'd2,
    running2  = 3'd3,
    ducking   = 3'd4,
    game_over = 3'd5
  } game_state_e;

  // ============================================================
  // widths
  // ============================================================
  typedef logic [1:0] game_tick_t;  // [0] frame tick, [1] physics tick
  typedef logic [5:0] height_t;     // 0 is ground
  typedef logic [5:0] xpos_t;
  typedef logic [9:0] score_t;      // wraps at 1023
  typedef logic [1:0] speed_t;

  // ============================================================
  // game constants
  // ============================================================
  localparam height_t jump_step   = 6'd4;
  localparam height_t jump_peak   = 6'd32;
  localparam xpos_t   player_col  = 6'd4;
  localparam xpos_t   track_start = 6'd63;
  localparam height_t cactus_top  = 6'd11;
  localparam height_t bird_low    = 6'd0;

  localparam logic [3:0] frame_period_0 = 4'd12;  // slowest
  localparam logic [3:0] frame_period_1 = 4'd8;
  localparam logic [3:0] frame_period_2 = 4'd6;
  localparam logic [3:0] frame_period_3 = 4'd4;

  localparam logic [7:0] lfsr_seed = 8'hA5;

endpackage

/* verilog/player_if.sv */
`timescale 1ns/100ps

// player status, controller to obstacle track
interface player_if import runner_pkg::*; ();

  height_t     position;
  game_state_e state;
  logic        frozen;
  logic        start_pulse;
  logic        over_pulse;
  logic        jump_pulse;

  modport ctrl (
    output position, state, frozen,
    output start_pulse, over_pulse, jump_pulse
  );

  modport track (
    input position, state, frozen,
    input start_pulse, over_pulse, jump_pulse
  );

endinterface

/* verilog/speed_config.sv */
`timescale 1ns/100ps

module speed_config import runner_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       cfg_wr,
  input  speed_t     cfg_speed,
  input  logic       frozen,
  output logic [3:0] frame_period
);

  speed_t speed_sel;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      speed_sel <= '0;
    end else if (cfg_wr && frozen) begin  // writes only between games
      speed_sel <= cfg_speed;
    end
  end

  // clocks per frame tick
  always_comb begin
    case (speed_sel)
      2'd0:    frame_period = frame_period_0;
      2'd1:    frame_period = frame_period_1;
      2'd2:    frame_period = frame_period_2;
      default: frame_period = frame_period_3;
    endcase
  end

endmodule

/* verilog/tick_gen.sv */
`timescale 1ns/100ps

module tick_gen import runner_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic [3:0] frame_period,
  output game_tick_t game_tick
);

  logic [3:0] count;
  logic       phase;       // toggles on each frame tick
  logic       frame_tick;

  // ============================================================
  // frame prescaler
  // ============================================================
  assign frame_tick = (count == 4'd0);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count <= frame_period - 4'd1;
    end else if (frame_tick) begin
      count <= frame_period - 4'd1;  // new period picked up here
    end else begin
      count <= count - 4'd1;
    end
  end

  // ============================================================
  // physics tick, every second frame
  // ============================================================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      phase <= 1'b0;
    end else if (frame_tick) begin
      phase <= ~phase;
    end
  end

  assign game_tick[0] = frame_tick;
  assign game_tick[1] = frame_tick && phase;

endmodule

/* verilog/player_physics.sv */
`timescale 1ns/100ps

module player_physics import runner_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  game_tick_t game_tick,
  input  logic       game_over,
  input  logic       jump_pulse,
  input  logic       button_down,
  output logic       jump_done,
  output height_t    position
);

  logic    rising;      // rise pending or in progress
  height_t pos_up;
  height_t pos_down;
  logic    on_ground;

  assign on_ground = (position == '0);
  assign pos_up    = position + jump_step;
  assign pos_down  = (position > jump_step) ? position - jump_step : '0;

  // ============================================================
  // jump arc
  // ============================================================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      position <= '0;
      rising   <= 1'b0;
    end else if (!game_over) begin  // everything holds after a crash
      if (button_down && on_ground) begin
        rising <= 1'b0;             // ducking cancels the jump
      end else if (jump_pulse) begin
        rising <= 1'b1;
      end else if (game_tick[1]) begin
        if (rising) begin
          if (pos_up >= jump_peak) begin
            position <= jump_peak;
            rising   <= 1'b0;       // top of the arc
          end else begin
            position <= pos_up;
          end
        end else if (!on_ground) begin
          position <= pos_down;
        end
      end
    end
  end

  assign jump_done = on_ground && !rising;

endmodule

/* verilog/player_controller.sv */
`timescale 1ns/100ps

module player_controller import runner_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  game_tick_t game_tick,
  input  logic       button_start,
  input  logic       button_up,
  input  logic       button_down,
  input  logic       crash,
  player_if.ctrl     pl
);

  game_state_e state;
  height_t     position;
  logic        running;
  logic        frozen;
  logic        jump_done;
  logic        jump_pulse;
  logic        physics_rst_n;
  logic        in_game_over;

  // ============================================================
  // game state machine
  // ============================================================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= restart;
    end else begin
      case (state)
        restart: begin
          if (game_tick[0] && button_start) state <= jumping;
        end
        jumping: begin
          if (crash)                          state <= game_over;
          else if (game_tick[1] && jump_done) state <= running1;
        end
        running1: begin
          if (crash)                            state <= game_over;
          else if (game_tick[0] && button_down) state <= ducking;
          else if (game_tick[0] && button_up)   state <= jumping;
          else if (game_tick[0])                state <= running2;
        end
        running2: begin
          if (crash)                            state <= game_over;
          else if (game_tick[0] && button_down) state <= ducking;
          else if (game_tick[0] && button_up)   state <= jumping;
          else if (game_tick[0])                state <= running1;
        end
        ducking: begin
          if (crash)                             state <= game_over;
          else if (game_tick[0] && !button_down) state <= running1;
        end
        game_over: begin
          if (game_tick[0] && button_start) state <= running1;  // skip the opening jump
        end
        default: state <= restart;
      endcase
    end
  end

  assign in_game_over = (state == game_over);
  assign running      = (state == running1) || (state == running2);
  assign frozen       = (state == restart) || in_game_over;

  // restart out of game over puts the player back on the ground
  assign physics_rst_n = rst_n && !(in_game_over && game_tick[0] && button_start);

  assign jump_pulse = running && game_tick[0] && button_up;

  player_physics u_player_physics (
    .clk         (clk),
    .rst_n       (physics_rst_n),
    .game_tick   (game_tick),
    .game_over   (in_game_over),
    .jump_pulse  (jump_pulse),
    .button_down (button_down),
    .jump_done   (jump_done),
    .position    (position)
  );

  // ============================================================
  // status out
  // ============================================================
  assign pl.state       = state;
  assign pl.position    = position;
  assign pl.frozen      = frozen;
  assign pl.start_pulse = frozen && game_tick[0] && button_start;
  assign pl.over_pulse  = !in_game_over && game_tick[0] && crash;
  assign pl.jump_pulse  = jump_pulse;

endmodule

/* verilog/obstacle_track.sv */
`timescale 1ns/100ps

module obstacle_track import runner_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  game_tick_t game_tick,
  player_if.track    pl,
  output logic       crash,
  output xpos_t      obstacle_x,
  output logic       obstacle_kind,  // 0 cactus, 1 bird
  output score_t     score
);

  logic [7:0] lfsr;
  logic       lfsr_fb;
  logic       scroll;
  logic       wrap;
  logic       hit_cactus;
  logic       hit_bird;

  // taps 8 6 5 4
  assign lfsr_fb = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];

  assign scroll = game_tick[0] && !pl.frozen;  // track holds while frozen
  assign wrap   = (obstacle_x == '0);

  // ============================================================
  // scroll, obstacle kind and score
  // ============================================================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      obstacle_x    <= track_start;
      obstacle_kind <= 1'b0;
      lfsr          <= lfsr_seed;
      score         <= '0;
    end else if (pl.start_pulse) begin
      obstacle_x <= track_start;  // clean start after game over
      score      <= '0;
    end else if (scroll) begin
      if (wrap) begin
        obstacle_x    <= track_start;
        score         <= score + 10'd1;
        lfsr          <= {lfsr[6:0], lfsr_fb};
        obstacle_kind <= lfsr_fb;  // new bit 0
      end else begin
        obstacle_x <= obstacle_x - 6'd1;
      end
    end
  end

  // ============================================================
  // crash detect
  // ============================================================
  assign hit_cactus = !obstacle_kind && (pl.position <= cactus_top);
  assign hit_bird   = obstacle_kind && (pl.state != ducking);

  assign crash = (obstacle_x == player_col) && (hit_cactus || hit_bird);

endmodule

/* verilog/runner_top.sv */
`timescale 1ns/100ps

module runner_top import runner_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       button_start,
  input  logic       button_up,
  input  logic       button_down,
  input  logic       cfg_wr,
  input  speed_t     cfg_speed,
  output logic [2:0] game_state,
  output height_t    player_position,
  output logic       game_frozen,
  output logic       frame_tick,
  output xpos_t      obstacle_x,
  output logic       obstacle_kind,
  output score_t     score
);

  game_tick_t game_tick;
  logic [3:0] frame_period;
  logic       crash;

  player_if pl_bus ();

  speed_config u_speed_config (
    .clk          (clk),
    .rst_n        (rst_n),
    .cfg_wr       (cfg_wr),
    .cfg_speed    (cfg_speed),
    .frozen       (pl_bus.frozen),
    .frame_period (frame_period)
  );

  tick_gen u_tick_gen (
    .clk          (clk),
    .rst_n        (rst_n),
    .frame_period (frame_period),
    .game_tick    (game_tick)
  );

  player_controller u_player_controller (
    .clk          (clk),
    .rst_n        (rst_n),
    .game_tick    (game_tick),
    .button_start (button_start),
    .button_up    (button_up),
    .button_down  (button_down),
    .crash        (crash),
    .pl           (pl_bus.ctrl)
  );

  obstacle_track u_obstacle_track (
    .clk           (clk),
    .rst_n         (rst_n),
    .game_tick     (game_tick),
    .pl            (pl_bus.track),
    .crash         (crash),
    .obstacle_x    (obstacle_x),
    .obstacle_kind (obstacle_kind),
    .score         (score)
  );

  assign game_state      = 3'(pl_bus.state);  // enum out as plain bits
  assign player_position = pl_bus.position;
  assign game_frozen     = pl_bus.frozen;
  assign frame_tick      = game_tick[0];

endmodule

/* tests/runner_tb.sv */
`timescale 1ns/100ps

module runner_tb;

  localparam string stim_file  = "tests/runner_input.txt";
  localparam int    num_fields = 12;
  localparam int    max_steps  = 64;

  // columns of a stimulus line
  localparam int f_wr     = 0;
  localparam int f_speed  = 1;
  localparam int f_start  = 2;
  localparam int f_up     = 3;
  localparam int f_down   = 4;
  localparam int f_ticks  = 5;
  localparam int f_state  = 6;
  localparam int f_pos    = 7;
  localparam int f_x      = 8;
  localparam int f_kind   = 9;
  localparam int f_score  = 10;
  localparam int f_period = 11;

  logic       clk;
  logic       rst_n;
  logic       button_start;
  logic       button_up;
  logic       button_down;
  logic       cfg_wr;
  logic [1:0] cfg_speed;
  logic [2:0] game_state;
  logic [5:0] player_position;
  logic       game_frozen;
  logic       frame_tick;
  logic [5:0] obstacle_x;
  logic       obstacle_kind;
  logic [9:0] score;

  int steps[0:max_steps-1][0:num_fields-1];
  int step_count   = 0;
  int mismatches   = 0;
  int other_errors = 0;
  int cycles       = 0;
  int cycle_limit  = 0;  // 0 until the file is read

  runner_top u_dut (
    .clk             (clk),
    .rst_n           (rst_n),
    .button_start    (button_start),
    .button_up       (button_up),
    .button_down     (button_down),
    .cfg_wr          (cfg_wr),
    .cfg_speed       (cfg_speed),
    .game_state      (game_state),
    .player_position (player_position),
    .game_frozen     (game_frozen),
    .frame_tick      (frame_tick),
    .obstacle_x      (obstacle_x),
    .obstacle_kind   (obstacle_kind),
    .score           (score)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ============================================================
  // stimulus file
  // ============================================================
  task automatic read_stimulus();
    int    fd;
    int    n;
    int    k;
    int    line_no;
    string line;
    int    v[num_fields];
    fd = $fopen(stim_file, "r");
    if (fd == 0) begin
      $display("error: cannot open stimulus file %s", stim_file);
      other_errors++;
      return;
    end
    line_no = 0;
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      line_no++;
      if (n == 0 || line.len() < 2 || line.getc(0) == "#") continue;  // blank or comment
      n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d",
                  v[0], v[1], v[2], v[3], v[4], v[5],
                  v[6], v[7], v[8], v[9], v[10], v[11]);
      if (n != num_fields || v[f_ticks] < 1 || step_count >= max_steps) begin
        $display("error: line %0d of %s is malformed", line_no, stim_file);
        other_errors++;
      end else begin
        for (k = 0; k < num_fields; k++) begin
          steps[step_count][k] = v[k];
        end
        step_count++;
      end
    end
    $fclose(fd);
  endtask

  // ============================================================
  // driver and checks
  // ============================================================
  task automatic check_value(input int step, input string field,
                             input int got, input int expected);
    assert (got == expected) else begin
      $display("mismatch at %0t: step %0d %s is %0d, expected %0d",
               $time, step, field, got, expected);
      mismatches++;
    end
  endtask

  // the game is frozen in restart and in game over
  function automatic int frozen_for_state(input int state);
    return (state == 0 || state == 5) ? 1 : 0;
  endfunction

  task automatic release_inputs();
    button_start = 1'b0;
    button_up    = 1'b0;
    button_down  = 1'b0;
    cfg_wr       = 1'b0;
  endtask

  task automatic run_step(input int idx);
    int seen;
    int since;
    int period;
    seen   = 0;
    since  = 0;
    period = 0;
    @(posedge clk);
    #2;
    cfg_wr       = (steps[idx][f_wr] != 0);
    cfg_speed    = 2'(steps[idx][f_speed]);
    button_start = (steps[idx][f_start] != 0);
    button_up    = (steps[idx][f_up] != 0);
    button_down  = (steps[idx][f_down] != 0);
    while (seen < steps[idx][f_ticks]) begin
      @(negedge clk);  // mid cycle, outputs settled
      since++;
      if (frame_tick) begin
        seen++;
        if (seen >= 2) period = since;  // clocks since the previous tick
        since = 0;
        @(posedge clk);
        #2;
        if (seen == 1) release_inputs();
      end
    end
    check_value(idx + 1, "game_state", int'(game_state), steps[idx][f_state]);
    check_value(idx + 1, "player_position", int'(player_position), steps[idx][f_pos]);
    check_value(idx + 1, "obstacle_x", int'(obstacle_x), steps[idx][f_x]);
    check_value(idx + 1, "obstacle_kind", int'(obstacle_kind), steps[idx][f_kind]);
    check_value(idx + 1, "score", int'(score), steps[idx][f_score]);
    check_value(idx + 1, "game_frozen", int'(game_frozen),
                frozen_for_state(steps[idx][f_state]));
    if (steps[idx][f_period] != 0) begin
      check_value(idx + 1, "frame period", period, steps[idx][f_period]);
    end
  endtask

  task automatic print_summary();
    $display("errors: %0d mismatches, %0d other", mismatches, other_errors);
  endtask

  // ============================================================
  // timeout
  // ============================================================
  always @(posedge clk) begin
    cycles++;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("error: timeout after %0d clock cycles", cycles);
      other_errors++;
      print_summary();
      $display("Simulation FAILED");
      $finish;
    end
  end

  initial begin
    int total_ticks;
    int i;
    rst_n        = 1'b0;
    button_start = 1'b0;
    button_up    = 1'b0;
    button_down  = 1'b0;
    cfg_wr       = 1'b0;
    cfg_speed    = 2'd0;
    total_ticks  = 0;
    read_stimulus();
    if (step_count == 0) begin
      $display("error: no test steps were read");
      other_errors++;
    end
    for (i = 0; i < step_count; i++) begin
      total_ticks += steps[i][f_ticks];
    end
    cycle_limit = total_ticks * 12 + 200;  // slowest speed is 12 clocks per tick
    repeat (3) @(posedge clk);
    #2;
    rst_n = 1'b1;
    for (i = 0; i < step_count; i++) begin
      run_step(i);
    end
    print_summary();
    if (mismatches == 0 && other_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* all.f */
verilog/runner_pkg.sv
verilog/player_if.sv
verilog/speed_config.sv
verilog/tick_gen.sv
verilog/player_physics.sv
verilog/player_controller.sv
verilog/obstacle_track.sv
verilog/runner_top.sv
tests/runner_tb.sv

/* Makefile */
VERILATOR := verilator
FLAGS     := --binary --timing --assert --timescale 1ns/100ps
LINTFLAGS := --lint-only -Wall --timing --timescale 1ns/100ps
TOP       := runner_tb
RTL_TOP   := runner_top
FILELIST  := all.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Simulation PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only if the log holds the pass line
run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "run failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tests/runner_input.txt */
# wr speed start up down ticks | expected: state position obstacle_x kind score period
# states 0 restart 1 jumping 2 running1 3 running2 4 ducking 5 game_over, period 0 unchecked
0 0 0 0 0 2  0 0  63 0 0 12
1 3 0 0 0 3  0 0  63 0 0 4
0 0 1 0 0 1  1 0  63 0 0 0
0 0 0 0 0 2  2 0  61 0 0 4
0 0 0 1 0 1  1 0  60 0 0 0
0 0 0 0 0 2  1 4  58 0 0 4
0 0 0 0 0 14 1 32 44 0 0 4
0 0 0 0 0 14 1 4  30 0 0 4
0 0 0 0 0 3  2 0  27 0 0 4
0 0 0 0 0 3  3 0  24 0 0 4
0 0 0 1 0 1  1 0  23 0 0 0
0 0 0 0 0 16 1 32 7  0 0 4
0 0 0 0 0 4  1 24 3  0 0 4
0 0 0 0 0 4  1 16 63 0 1 4
0 0 0 0 0 10 2 0  53 0 1 4
1 0 0 0 0 31 3 0  22 0 1 4
0 0 0 1 0 1  1 0  21 0 1 0
0 0 0 0 0 16 1 32 5  0 1 4
0 0 0 0 0 4  1 24 1  0 1 4
0 0 0 0 0 2  1 20 63 1 2 4
0 0 0 0 0 12 2 0  51 1 2 4
0 0 0 0 0 46 2 0  5  1 2 4
0 0 0 0 1 1  4 0  4  1 2 0
0 0 0 0 0 1  2 0  3  1 2 0
0 0 0 0 0 4  2 0  63 0 3 4
0 0 0 0 0 58 2 0  5  0 3 4
0 0 0 0 0 3  5 0  4  0 3 4
0 0 0 1 0 4  5 0  4  0 3 4
1 1 0 0 0 3  5 0  4  0 3 8
0 1 1 0 0 1  2 0  63 0 0 0
0 1 0 0 0 3  3 0  60 0 0 8
